// File: src.f
+incdir+verilog
verilog/rf_types_pkg.sv
verilog/rf_port_pkg.sv
verilog/rf_storage.sv
verilog/rf_read_port.sv
verilog/rf_2r1w.sv
sim/tb_rf_2r1w.sv

// File: Bender.yml
package:
  name: rf_2r1w

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rf_types_pkg.sv
      - verilog/rf_port_pkg.sv
      - verilog/rf_storage.sv
      - verilog/rf_read_port.sv
      - verilog/rf_2r1w.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/tb_rf_2r1w.sv

// File: sim/rf_golden.txt
# name wr_en wr_addr wr_data rd0_en rd0_addr rd1_en rd1_addr exp_rd0_data exp_rd1_data
# all fields hex, expected data is what each port shows in the cycle after the vector's edge
reset_idle 0 00 00000000 0 00 0 00 ffffffff ffffffff
reset_idle 0 00 00000000 0 00 0 00 ffffffff ffffffff
reset_idle 0 00 00000000 0 00 0 00 ffffffff ffffffff
fill 1 00 d000c31f 0 00 0 00 ffffffff ffffffff
fill 1 01 d001c31e 0 00 0 00 ffffffff ffffffff
fill 1 02 d002c31d 0 00 0 00 ffffffff ffffffff
fill 1 03 d003c31c 0 00 0 00 ffffffff ffffffff
fill 1 04 d004c31b 0 00 0 00 ffffffff ffffffff
fill 1 05 d005c31a 0 00 0 00 ffffffff ffffffff
fill 1 06 d006c319 0 00 0 00 ffffffff ffffffff
fill 1 07 d007c318 0 00 0 00 ffffffff ffffffff
fill 1 08 d008c317 0 00 0 00 ffffffff ffffffff
fill 1 09 d009c316 0 00 0 00 ffffffff ffffffff
fill 1 0a d00ac315 0 00 0 00 ffffffff ffffffff
fill 1 0b d00bc314 0 00 0 00 ffffffff ffffffff
fill 1 0c d00cc313 0 00 0 00 ffffffff ffffffff
fill 1 0d d00dc312 0 00 0 00 ffffffff ffffffff
fill 1 0e d00ec311 0 00 0 00 ffffffff ffffffff
fill 1 0f d00fc310 0 00 0 00 ffffffff ffffffff
fill 1 10 d010c30f 0 00 0 00 ffffffff ffffffff
fill 1 11 d011c30e 0 00 0 00 ffffffff ffffffff
fill 1 12 d012c30d 0 00 0 00 ffffffff ffffffff
fill 1 13 d013c30c 0 00 0 00 ffffffff ffffffff
fill 1 14 d014c30b 0 00 0 00 ffffffff ffffffff
fill 1 15 d015c30a 0 00 0 00 ffffffff ffffffff
fill 1 16 d016c309 0 00 0 00 ffffffff ffffffff
fill 1 17 d017c308 0 00 0 00 ffffffff ffffffff
fill 1 18 d018c307 0 00 0 00 ffffffff ffffffff
fill 1 19 d019c306 0 00 0 00 ffffffff ffffffff
fill 1 1a d01ac305 0 00 0 00 ffffffff ffffffff
fill 1 1b d01bc304 0 00 0 00 ffffffff ffffffff
fill 1 1c d01cc303 0 00 0 00 ffffffff ffffffff
fill 1 1d d01dc302 0 00 0 00 ffffffff ffffffff
fill 1 1e d01ec301 0 00 0 00 ffffffff ffffffff
fill 1 1f d01fc300 0 00 0 00 ffffffff ffffffff
read_seq 0 00 00000000 1 00 0 00 d000c31f ffffffff
read_seq 0 00 00000000 1 1f 0 00 d01fc300 ffffffff
read_seq 0 00 00000000 1 01 0 00 d001c31e ffffffff
read_seq 0 00 00000000 1 1e 0 00 d01ec301 ffffffff
read_seq 0 00 00000000 1 02 0 00 d002c31d ffffffff
read_seq 0 00 00000000 1 1d 0 00 d01dc302 ffffffff
read_seq 0 00 00000000 1 03 0 00 d003c31c ffffffff
read_seq 0 00 00000000 1 10 0 00 d010c30f ffffffff
read_seq 0 00 00000000 1 0f 0 00 d00fc310 ffffffff
read_seq 0 00 00000000 1 08 0 00 d008c317 ffffffff
read_seq 0 00 00000000 1 07 0 00 d007c318 ffffffff
read_seq 0 00 00000000 1 18 0 00 d018c307 ffffffff
read_seq 0 00 00000000 1 11 0 00 d011c30e ffffffff
read_seq 0 00 00000000 1 04 0 00 d004c31b ffffffff
read_seq 0 00 00000000 1 0c 0 00 d00cc313 ffffffff
read_seq 0 00 00000000 1 13 0 00 d013c30c ffffffff
read_seq 0 00 00000000 1 1a 0 00 d01ac305 ffffffff
read_seq 0 00 00000000 1 05 0 00 d005c31a ffffffff
read_seq 0 00 00000000 1 16 0 00 d016c309 ffffffff
read_seq 0 00 00000000 1 0b 0 00 d00bc314 ffffffff
dual_read 0 00 00000000 1 00 1 1f d000c31f d01fc300
dual_read 0 00 00000000 1 01 1 1e d001c31e d01ec301
dual_read 0 00 00000000 1 02 1 1d d002c31d d01dc302
dual_read 0 00 00000000 1 03 1 1c d003c31c d01cc303
dual_read 0 00 00000000 1 0a 1 15 d00ac315 d015c30a
dual_read 0 00 00000000 1 0b 1 14 d00bc314 d014c30b
dual_read 0 00 00000000 1 0c 1 13 d00cc313 d013c30c
dual_read 0 00 00000000 1 17 1 06 d017c308 d006c319
dual_read 0 00 00000000 1 19 1 0e d019c306 d00ec311
dual_read 0 00 00000000 1 12 1 0d d012c30d d00dc312
dual_read 0 00 00000000 1 07 1 07 d007c318 d007c318
dual_read 0 00 00000000 1 1b 1 1b d01bc304 d01bc304
dual_read 0 00 00000000 1 00 1 00 d000c31f d000c31f
dual_read 0 00 00000000 1 1f 1 1f d01fc300 d01fc300
wr_bypass 1 04 1ace0004 1 04 1 05 1ace0004 d005c31a
wr_bypass 1 05 1ace0005 1 05 1 04 1ace0005 1ace0004
wr_bypass 1 06 1ace0006 1 06 1 06 1ace0006 1ace0006
wr_bypass 1 1f 1ace001f 1 1f 0 00 1ace001f ffffffff
wr_bypass 1 00 1ace0000 1 00 1 1f 1ace0000 1ace001f
wr_bypass 1 10 1ace0010 1 10 1 11 1ace0010 d011c30e
wr_bypass 1 10 2bad0010 1 10 1 10 2bad0010 2bad0010
wr_bypass 1 08 1ace0008 0 00 1 08 ffffffff 1ace0008
wr_bypass 1 0c 1ace000c 1 0c 1 0d 1ace000c d00dc312
wr_bypass 0 00 00000000 1 04 1 0c 1ace0004 1ace000c
wr_disabled 0 09 deadbeef 0 00 0 00 ffffffff ffffffff
wr_disabled 0 00 00000000 1 09 0 00 d009c316 ffffffff
wr_disabled 0 0a 0badf00d 1 0a 1 0a d00ac315 d00ac315
wr_disabled 0 04 feedface 1 04 0 00 1ace0004 ffffffff
wr_disabled 0 1f 12345678 0 00 1 1f ffffffff 1ace001f
wr_disabled 0 00 00000000 1 1f 1 09 1ace001f d009c316
wr_disabled 0 0d cafe0000 1 0d 0 00 d00dc312 ffffffff
wr_disabled 0 00 00000000 1 0a 1 04 d00ac315 1ace0004
idle_port 0 00 00000000 0 03 1 03 ffffffff d003c31c
idle_port 0 00 00000000 1 13 0 13 d013c30c ffffffff
idle_port 0 00 00000000 0 1e 1 1e ffffffff d01ec301
idle_port 0 00 00000000 1 10 0 0e 2bad0010 ffffffff
idle_port 0 00 00000000 0 00 0 00 ffffffff ffffffff
idle_port 0 00 00000000 1 08 0 1f 1ace0008 ffffffff
idle_port 0 00 00000000 0 08 1 06 ffffffff 1ace0006
idle_port 0 00 00000000 1 14 1 15 d014c30b d015c30a
idle_port 0 00 00000000 0 14 0 15 ffffffff ffffffff
idle_port 0 00 00000000 1 1c 0 1d d01cc303 ffffffff

// File: sim/tb_rf_2r1w.sv
// testbench for the two-read, one-write register file, driven from a golden vector file
`timescale 1ns/10ps

`include "rf_consts.svh"

module tb_rf_2r1w;

  localparam int MAX_VECS = 256;
  localparam int NAME_W   = 8*16; // test names up to 16 characters
  localparam int LINE_W   = 8*256;

  logic                    clk;
  logic                    reset;
  rf_port_pkg::rf_wr_req_t wr;
  rf_port_pkg::rf_rd_req_t rd0;
  rf_port_pkg::rf_rd_req_t rd1;
  rf_types_pkg::rf_data_t  rd0_data;
  rf_types_pkg::rf_data_t  rd1_data;

  // ----------------------------------------
  // vectors loaded from the golden file
  // ----------------------------------------
  logic [NAME_W-1:0]       vec_name [MAX_VECS];
  rf_port_pkg::rf_wr_req_t vec_wr   [MAX_VECS];
  rf_port_pkg::rf_rd_req_t vec_rd0  [MAX_VECS];
  rf_port_pkg::rf_rd_req_t vec_rd1  [MAX_VECS];
  rf_types_pkg::rf_data_t  vec_exp0 [MAX_VECS];
  rf_types_pkg::rf_data_t  vec_exp1 [MAX_VECS];
  int                      vec_count;
  bit                      load_ok;

  int cycle_count = 0;
  int cycle_limit = 50; // raised once the vector count is known
  int test_errors = 0;  // mismatches in the running test
  int tests_passed = 0;
  int tests_failed = 0;

  rf_2r1w uut (
    .clk      (clk),
    .reset    (reset),
    .wr       (wr),
    .rd0      (rd0),
    .rd1      (rd1),
    .rd0_data (rd0_data),
    .rd1_data (rd1_data)
  );

  // ----------------------------------------
  // clock and timeout
  // ----------------------------------------
  initial clk = 1'b0;
  always #20 clk = ~clk; // 40 ns period

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run went past %0d cycles without finishing the vectors", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // reads every vector line, skips blank lines and lines whose first token is #
  task automatic load_vectors(output int count, output bit ok);
    int                      fd;
    int                      n;
    logic [LINE_W-1:0]       text_line;
    logic [NAME_W-1:0]       name;
    logic [31:0]             f_we, f_wa, f_wd, f_r0e, f_r0a, f_r1e, f_r1a, f_e0, f_e1;
    rf_port_pkg::rf_wr_req_t w;
    rf_port_pkg::rf_rd_req_t r0;
    rf_port_pkg::rf_rd_req_t r1;
    count = 0;
    ok = 1'b1;
    fd = $fopen("sim/rf_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden vector file sim/rf_golden.txt");
      ok = 1'b0;
    end else begin
      text_line = '0;
      n = $fgets(text_line, fd);
      while (n != 0 && ok) begin
        name = '0;
        n = $sscanf(text_line, "%s", name);
        if (n == 1 && name != "#") begin
          n = $sscanf(text_line, "%s %h %h %h %h %h %h %h %h %h", name,
                      f_we, f_wa, f_wd, f_r0e, f_r0a, f_r1e, f_r1a, f_e0, f_e1);
          if (n != 10) begin
            $display("golden file line %0d has %0d fields instead of 10", count + 1, n);
            ok = 1'b0;
          end else if (count >= MAX_VECS) begin
            $display("golden file holds more than %0d vectors", MAX_VECS);
            ok = 1'b0;
          end else begin
            w.en     = f_we[0];
            w.addr   = f_wa[`RF_ADDR_W-1:0];
            w.data   = f_wd[`RF_DATA_W-1:0];
            r0.en    = f_r0e[0];
            r0.addr  = f_r0a[`RF_ADDR_W-1:0];
            r1.en    = f_r1e[0];
            r1.addr  = f_r1a[`RF_ADDR_W-1:0];
            vec_name[count] = name;
            vec_wr[count]   = w;
            vec_rd0[count]  = r0;
            vec_rd1[count]  = r1;
            vec_exp0[count] = f_e0[`RF_DATA_W-1:0];
            vec_exp1[count] = f_e1[`RF_DATA_W-1:0];
            count = count + 1;
          end
        end
        text_line = '0;
        n = $fgets(text_line, fd);
      end
      $fclose(fd);
      if (ok && count == 0) begin
        $display("golden file holds no vectors");
        ok = 1'b0;
      end
    end
  endtask

  task automatic drive_vector(input int idx);
    wr  = vec_wr[idx];
    rd0 = vec_rd0[idx];
    rd1 = vec_rd1[idx];
  endtask

  task automatic check_data(input logic [NAME_W-1:0] name, input string port,
                            input rf_types_pkg::rf_data_t expected,
                            input rf_types_pkg::rf_data_t actual);
    if (actual !== expected) begin
      $display("ERROR %0s %0s: expected %h, actual %h", name, port, expected, actual);
      test_errors = test_errors + 1;
    end
  endtask

  // one result line per test
  task automatic close_test(input logic [NAME_W-1:0] name);
    if (test_errors == 0) begin
      $display("test %0s: pass", name);
      tests_passed = tests_passed + 1;
    end else begin
      $display("test %0s: fail with %0d mismatches", name, test_errors);
      tests_failed = tests_failed + 1;
    end
    test_errors = 0;
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    logic [NAME_W-1:0] cur_name;
    reset = 1'b1;
    wr    = '0;
    rd0   = '0;
    rd1   = '0;
    rd0.en = 1'b1; // read strobes stay high through reset
    rd1.en = 1'b1;
    load_vectors(vec_count, load_ok);
    if (load_ok) begin
      cycle_limit = 2 * vec_count + 50;
      repeat (4) @(posedge clk);
      @(negedge clk);
      // staged enables cleared by reset alone
      check_data("reset", "rd0", `RF_IDLE_DATA, rd0_data);
      check_data("reset", "rd1", `RF_IDLE_DATA, rd1_data);
      close_test("reset");
      reset = 1'b0;
      cur_name = vec_name[0];
      for (int i = 0; i < vec_count; i++) begin
        if (vec_name[i] != cur_name) begin
          close_test(cur_name);
          cur_name = vec_name[i];
        end
        drive_vector(i);
        @(negedge clk); // outputs settled one cycle after the edge
        check_data(vec_name[i], "rd0", vec_exp0[i], rd0_data);
        check_data(vec_name[i], "rd1", vec_exp1[i], rd1_data);
      end
      close_test(cur_name);
    end
    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (load_ok && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: verilog/rf_2r1w.sv
// 32-entry, 32-bit register file with one write port and two read ports
`timescale 1ns/10ps

`include "rf_consts.svh"

module rf_2r1w (
  input  logic                     clk,
  input  logic                     reset,

  // write port
  input  rf_port_pkg::rf_wr_req_t  wr,

  // read requests
  input  rf_port_pkg::rf_rd_req_t  rd0,
  input  rf_port_pkg::rf_rd_req_t  rd1,

  // read data, one cycle after each request
  output rf_types_pkg::rf_data_t   rd0_data,
  output rf_types_pkg::rf_data_t   rd1_data
);

  // full array, shared by both read ports
  rf_types_pkg::rf_data_t [`RF_DEPTH-1:0] entries;

  // ----------------------------------------
  // storage
  // ----------------------------------------

  rf_storage u_storage (
    .clk     (clk),
    .wr      (wr),
    .entries (entries)
  );

  // ----------------------------------------
  // read ports
  // ----------------------------------------

  // port 0
  rf_read_port u_rd0 (
    .clk     (clk),
    .reset   (reset),
    .rd      (rd0),
    .entries (entries),
    .rd_data (rd0_data)
  );

  // port 1, independent of port 0
  rf_read_port u_rd1 (
    .clk     (clk),
    .reset   (reset),
    .rd      (rd1),
    .entries (entries),
    .rd_data (rd1_data)
  );

endmodule

// File: verilog/rf_read_port.sv
// register file read port with address staging, select decode and and-or read mux
`timescale 1ns/10ps

`include "rf_consts.svh"

module rf_read_port (
  input  logic                                    clk,
  input  logic                                    reset,
  input  rf_port_pkg::rf_rd_req_t                 rd,       // read strobe and address
  input  rf_types_pkg::rf_data_t [`RF_DEPTH-1:0]  entries,  // from storage
  output rf_types_pkg::rf_data_t                  rd_data   // valid the cycle after rd.en
);

  rf_types_pkg::rf_addr_t rd_addr_q; // staged address
  logic                   rd_en_q;   // staged enable
  rf_types_pkg::rf_sel_t  rd_sel;    // decoded staged address
  rf_types_pkg::rf_data_t rd_raw;    // and-or of selected entry

  // ----------------------------------------
  // request staging
  // ----------------------------------------

  // address only moves on a real read and holds otherwise
  always_ff @(posedge clk) begin
    if (rd.en) begin
      rd_addr_q <= rd.addr;
    end
  end

  // enable follows rd.en every cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= rd.en;
    end
  end

  // ----------------------------------------
  // select decode
  // ----------------------------------------

  always_comb begin
    rd_sel = '0;
    for (int i = 0; i < `RF_DEPTH; i++) begin
      rd_sel[i] = (rd_addr_q == rf_types_pkg::rf_addr_t'(i));
    end
  end

  // ----------------------------------------
  // read mux
  // ----------------------------------------

  // only the selected entry survives the and-or
  always_comb begin
    rd_raw = '0;
    for (int i = 0; i < `RF_DEPTH; i++) begin
      rd_raw = rd_raw | ({`RF_DATA_W{rd_sel[i]}} & entries[i]);
    end
  end

  // all ones when no read was staged
  assign rd_data = rd_en_q ? rd_raw : `RF_IDLE_DATA;

  // ----------------------------------------
  // checks
  // ----------------------------------------

  // a staged read always points at exactly one entry
  a_rd_sel_onehot : assert property (
    @(posedge clk) rd_en_q |-> $onehot(rd_sel)
  ) else $error("read select not one-hot while a read is staged: %h", rd_sel);

  // no read staged in the cycle after reset
  a_rd_en_reset : assert property (
    @(posedge clk) reset |=> !rd_en_q
  ) else $error("staged read enable survived reset");

  // a read strobe with a known address returns exactly that entry next cycle
  a_rd_returns_entry : assert property (
    @(posedge clk) disable iff (reset)
      (rd.en && !$isunknown(rd.addr)) |=> rd_data == entries[$past(rd.addr)]
  ) else $error("read data does not match the requested entry");

endmodule

// File: verilog/rf_storage.sv
// register file entry array with write address decode and enabled entry registers
`timescale 1ns/10ps

`include "rf_consts.svh"

module rf_storage (
  input  logic                                    clk,
  input  rf_port_pkg::rf_wr_req_t                 wr,      // write strobe, address, data
  output rf_types_pkg::rf_data_t [`RF_DEPTH-1:0]  entries  // all entries for the read ports
);

  rf_types_pkg::rf_sel_t wr_sel_raw; // decoded address before en gating
  rf_types_pkg::rf_sel_t wr_sel;     // per-entry load enables

  // ----------------------------------------
  // write address decode
  // ----------------------------------------

  // one bit per entry matching wr.addr
  always_comb begin
    wr_sel_raw = '0;
    for (int i = 0; i < `RF_DEPTH; i++) begin
      if (wr.addr == rf_types_pkg::rf_addr_t'(i)) begin
        wr_sel_raw[i] = 1'b1;
      end
    end
  end

  // nothing selected while the strobe is low
  assign wr_sel = wr_sel_raw & {`RF_DEPTH{wr.en}};

  // ----------------------------------------
  // entry registers
  // ----------------------------------------

  // each entry loads on its own select and holds otherwise
  always_ff @(posedge clk) begin
    for (int i = 0; i < `RF_DEPTH; i++) begin
      if (wr_sel[i]) begin
        entries[i] <= wr.data;
      end
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------

  // at most one entry may load on any edge
  a_wr_sel_onehot0 : assert property (
    @(posedge clk) $onehot0(wr_sel)
  ) else $error("write select has more than one entry enabled: %h", wr_sel);

  // a write with an unknown address would corrupt some unknown set of entries
  a_wr_addr_known : assert property (
    @(posedge clk) wr.en |-> !$isunknown(wr.addr)
  ) else $error("write strobe with unknown address");

endmodule

// File: verilog/rf_port_pkg.sv
// packed request structs for the register file write and read ports
package rf_port_pkg;

  `include "rf_consts.svh"

  // ----------------------------------------
  // write port
  // ----------------------------------------

  // strobe, takes effect on the edge where en is high
  typedef struct packed {
    logic                   en;   // write strobe
    rf_types_pkg::rf_addr_t addr; // target entry
    rf_types_pkg::rf_data_t data; // new contents
  } rf_wr_req_t;

  // ----------------------------------------
  // read port
  // ----------------------------------------

  // data comes back one cycle after the strobe
  typedef struct packed {
    logic                   en;   // read strobe
    rf_types_pkg::rf_addr_t addr; // entry to read
  } rf_rd_req_t;

endpackage

// File: verilog/rf_types_pkg.sv
// plain vector types for register file addresses, entry data and entry selects
package rf_types_pkg;

  `include "rf_consts.svh"

  // ----------------------------------------
  // entry addressing
  // ----------------------------------------

  // one of RF_DEPTH entries
  typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

  // one-hot, one bit per entry
  typedef logic [`RF_DEPTH-1:0] rf_sel_t;

  // ----------------------------------------
  // entry payload
  // ----------------------------------------

  typedef logic [`RF_DATA_W-1:0] rf_data_t; // contents of a single entry

endpackage

// File: verilog/rf_consts.svh
// register file geometry and idle read value constants
`ifndef RF_CONSTS_SVH
`define RF_CONSTS_SVH

// ----------------------------------------
// array geometry
// ----------------------------------------
`define RF_DEPTH 32
`define RF_DATA_W 32
`define RF_ADDR_W 5

// ----------------------------------------
// value driven by a read port with no staged read
`define RF_IDLE_DATA {`RF_DATA_W{1'b1}}

`endif
